// ==== rtl/riders_pkg.sv ====
// ----------------------------------------------------------
// Shared types and constants for the object DMA core
// Only two titles are known, any other game id is invalid
// Object RAM holds 128 words, the short table uses the first 64
// ----------------------------------------------------------
`default_nettype none

package riders_pkg;

    // Game identifiers as stored in the ROM header
    typedef logic [2:0] game_id_t;

    localparam game_id_t GAME_SSRIDERS = 3'd0;
    localparam game_id_t GAME_TMNT2    = 3'd1;

    // Object table length in words
    localparam int TBL_WORDS_SSR   = 64;
    localparam int TBL_WORDS_TMNT2 = 128;

    // Header byte holding the game id
    localparam logic [3:0] HDR_GAME_ADDR = 4'd15;

    // Data and address widths
    typedef logic [15:0] word_t;
    typedef logic [6:0]  oaddr_t;
    typedef logic [12:0] saddr_t;
    typedef logic [7:0]  dbg_t;

    // Protection register map, word address bit 0
    localparam logic REG_BASE = 1'b0;
    localparam logic REG_ACK  = 1'b1;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        ACK,
        COPY,
        DRAIN,
        IRQ
    } dma_state_t;

endpackage

`default_nettype wire

// ==== rtl/riders_dma_if.sv ====
// ----------------------------------------------------------
// DMA write port plus copy progress between the DMA blocks
// wdata comes straight from the main RAM read bus
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface riders_dma_if
    import riders_pkg::*;
();

    logic   busy;
    logic   step;
    logic   last;
    oaddr_t dst_addr;
    word_t  wdata;
    logic   we;

    modport ctrl (
        output busy,
        output step,
        output we,
        input  last
    );

    modport count (
        input  busy,
        input  step,
        output last,
        output dst_addr
    );

    modport ram (
        input dst_addr,
        input wdata,
        input we
    );

endinterface

`default_nettype wire

// ==== rtl/riders_cfg.sv ====
// ----------------------------------------------------------
// Game id latch from the header download and debug byte mux
// Only the low three bits of header byte 15 are kept
// debug_view lags its source by one clock
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module riders_cfg
    import riders_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] prog_addr,
    input  dbg_t       prog_data,
    input  logic       prog_we,
    input  logic       header,
    input  dbg_t       debug_bus,
    input  dbg_t       st_dma,
    input  oaddr_t     dma_index,
    output game_id_t   game_id,
    output dbg_t       debug_view
);

    logic hdr_wr;

    assign hdr_wr = prog_we && header && (prog_addr == HDR_GAME_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            game_id <= GAME_SSRIDERS;
        end else if (hdr_wr) begin
            game_id <= prog_data[2:0];
        end
    end

    // Page select on the top two debug bits
    always_ff @(posedge clk) begin
        if (rst) begin
            debug_view <= '0;
        end else begin
            case (debug_bus[7:6])
                2'd0:    debug_view <= st_dma;
                2'd1:    debug_view <= {1'b0, dma_index};
                2'd3:    debug_view <= {5'd0, game_id};
                default: debug_view <= '0;
            endcase
        end
    end

    // Header must name one of the supported titles
    a_known_game: assert property (@(posedge clk) disable iff (rst)
        $past(hdr_wr) |-> (game_id == GAME_SSRIDERS || game_id == GAME_TMNT2));

endmodule

`default_nettype wire

// ==== rtl/riders_dma_ctrl.sv ====
// ----------------------------------------------------------
// Protection chip DMA sequencer
// Bus request, grant and acknowledge are active low, 68000 style
// A base write is only taken in IDLE, later ones are dropped
// irq_n is a level held until the CPU writes REG_ACK
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module riders_dma_ctrl
    import riders_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cpu_we,
    input  logic         prot_cs,
    input  logic         reg_addr,
    input  word_t        cpu_din,
    input  logic         bus_grant_n,
    output logic         bus_req_n,
    output logic         bus_ack_n,
    output logic         irq_n,
    output saddr_t       src_base,
    output dbg_t         st_dma,
    riders_dma_if.ctrl   dma
);

    dma_state_t state;
    logic       base_wr;
    logic       ack_wr;

    assign base_wr = prot_cs && cpu_we && (reg_addr == REG_BASE);
    assign ack_wr  = prot_cs && cpu_we && (reg_addr == REG_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            dma.we <= 1'b0;
        end else begin
            // Data for each issued address lands one clock later
            dma.we <= dma.step;
            case (state)
                IDLE:    if (base_wr) state <= REQ;
                REQ:     if (!bus_grant_n) state <= ACK;
                ACK:     state <= COPY;
                COPY:    if (dma.last) state <= DRAIN;
                DRAIN:   state <= IRQ;
                IRQ:     if (ack_wr) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Source base register
    always_ff @(posedge clk) begin
        if (base_wr && state == IDLE) begin
            src_base <= saddr_t'(cpu_din);
        end
    end

    assign dma.busy  = (state == ACK) || (state == COPY) || (state == DRAIN);
    assign dma.step  = (state == COPY);
    assign bus_req_n = (state != REQ);
    assign bus_ack_n = !dma.busy;
    assign irq_n     = (state != IRQ);

    assign st_dma = {1'b0, bus_grant_n, bus_ack_n, bus_req_n, irq_n, state};

    a_req_ack_excl: assert property (@(posedge clk) disable iff (rst)
        !(!bus_req_n && !bus_ack_n));

    // Interrupt only follows the final object RAM write
    a_irq_after_drain: assert property (@(posedge clk) disable iff (rst)
        $fell(irq_n) |-> $past(state) == DRAIN);

    // CPU owns no bus cycles while the DMA holds the bus
    a_no_prot_in_dma: assert property (@(posedge clk) disable iff (rst)
        !bus_ack_n |-> !prot_cs);

endmodule

`default_nettype wire

// ==== rtl/riders_dma_count.sv ====
// ----------------------------------------------------------
// DMA word counter and address generator
// ram_addr is combinational, base plus index, wraps at 13 bits
// dst_addr trails the index by the one clock RAM latency
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module riders_dma_count
    import riders_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  game_id_t      game_id,
    input  saddr_t        src_base,
    output saddr_t        ram_addr,
    output oaddr_t        dma_index,
    riders_dma_if.count   dma
);

    oaddr_t tbl_last;
    logic   busy_q;
    logic   done;

    assign tbl_last = (game_id == GAME_TMNT2) ? oaddr_t'(TBL_WORDS_TMNT2 - 1)
                                              : oaddr_t'(TBL_WORDS_SSR - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q    <= 1'b0;
            dma_index <= '0;
            done      <= 1'b0;
        end else begin
            busy_q <= dma.busy;
            if (dma.busy && !busy_q) begin
                dma_index <= '0;
            end else if (dma.step) begin
                dma_index <= dma_index + 1'b1;
            end
            // Copy finished flag, held until the bus is returned
            if (!dma.busy) begin
                done <= 1'b0;
            end else if (dma.step && dma.last) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        dma.dst_addr <= dma_index;
    end

    assign dma.last = (dma_index == tbl_last);
    assign ram_addr = src_base + saddr_t'(dma_index);

    a_no_step_past_last: assert property (@(posedge clk) disable iff (rst)
        done |-> !dma.step);

endmodule

`default_nettype wire

// ==== rtl/riders_oram.sv ====
// ----------------------------------------------------------
// Object RAM, 128 x 16, single clock
// DMA writes win over CPU accesses
// CPU read data is registered, valid one clock after oram_cs
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module riders_oram
    import riders_pkg::*;
(
    input  logic        clk,
    input  logic        oram_cs,
    input  logic        cpu_we,
    input  oaddr_t      cpu_addr,
    input  word_t       cpu_din,
    output word_t       cpu_dout,
    riders_dma_if.ram   dma
);

    word_t mem [0:(2**$bits(oaddr_t))-1];

    // Write port shared between DMA and CPU
    always_ff @(posedge clk) begin
        if (dma.we) begin
            mem[dma.dst_addr] <= dma.wdata;
        end else if (oram_cs && cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
    end

    always_ff @(posedge clk) begin
        if (oram_cs && !cpu_we) begin
            cpu_dout <= mem[cpu_addr];
        end
    end

    // CPU is held off the bus for the whole copy
    a_no_cpu_in_dma: assert property (@(posedge clk)
        dma.we |-> !oram_cs);

endmodule

`default_nettype wire

// ==== rtl/riders_game.sv ====
// ----------------------------------------------------------
// Object DMA and game configuration top level
// The CPU side uses word addresses, cpu_addr[0] picks the
// protection register. Main RAM must answer in one clock
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module riders_game
    import riders_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // ROM download
    input  logic [3:0] prog_addr,
    input  dbg_t       prog_data,
    input  logic       prog_we,
    input  logic       header,
    // CPU bus
    input  oaddr_t     cpu_addr,
    input  word_t      cpu_din,
    input  logic       cpu_we,
    input  logic       prot_cs,
    input  logic       oram_cs,
    output word_t      cpu_dout,
    // Bus arbitration
    input  logic       bus_grant_n,
    output logic       bus_req_n,
    output logic       bus_ack_n,
    output logic       irq_n,
    // Main work RAM
    output saddr_t     ram_addr,
    input  word_t      ram_data,
    // Debug
    input  dbg_t       debug_bus,
    output dbg_t       debug_view
);

    game_id_t game_id;
    saddr_t   src_base;
    dbg_t     st_dma;
    oaddr_t   dma_index;

    riders_dma_if dma_bus ();

    assign dma_bus.wdata = ram_data;

    riders_cfg u_cfg (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .prog_addr  ( prog_addr   ),
        .prog_data  ( prog_data   ),
        .prog_we    ( prog_we     ),
        .header     ( header      ),
        .debug_bus  ( debug_bus   ),
        .st_dma     ( st_dma      ),
        .dma_index  ( dma_index   ),
        .game_id    ( game_id     ),
        .debug_view ( debug_view  )
    );

    riders_dma_ctrl u_ctrl (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .cpu_we      ( cpu_we      ),
        .prot_cs     ( prot_cs     ),
        .reg_addr    ( cpu_addr[0] ),
        .cpu_din     ( cpu_din     ),
        .bus_grant_n ( bus_grant_n ),
        .bus_req_n   ( bus_req_n   ),
        .bus_ack_n   ( bus_ack_n   ),
        .irq_n       ( irq_n       ),
        .src_base    ( src_base    ),
        .st_dma      ( st_dma      ),
        .dma         ( dma_bus     )
    );

    riders_dma_count u_count (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .game_id   ( game_id   ),
        .src_base  ( src_base  ),
        .ram_addr  ( ram_addr  ),
        .dma_index ( dma_index ),
        .dma       ( dma_bus   )
    );

    riders_oram u_oram (
        .clk      ( clk      ),
        .oram_cs  ( oram_cs  ),
        .cpu_we   ( cpu_we   ),
        .cpu_addr ( cpu_addr ),
        .cpu_din  ( cpu_din  ),
        .cpu_dout ( cpu_dout ),
        .dma      ( dma_bus  )
    );

endmodule

`default_nettype wire

// ==== verification/tb_clk.sv ====
// ------------------------------------------------------------
// Free running testbench clock, 8 ns period
// First rising edge at 4 ns
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clk (
    output logic clk
);

    localparam int HALF_NS = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verification/tb_riders.sv ====
// ------------------------------------------------------------
// Testbench for the object DMA core, random stimulus from seed 97132
// Main work RAM answers one clock after ram_addr, grant after 0..5
// Inputs change 1 ns after the rising edge, outputs read there too
// ------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_riders
    import riders_pkg::*;
();

    localparam int SEED      = 97132;
    localparam int N_ROUNDS  = 2;
    localparam int N_MIX     = 200;
    localparam int GRANT_MAX = 5;
    localparam int CLK_NS    = 8;
    // Prefill, copy and readback of the long table, per copy run
    localparam int RUN_CYCLES  = 3 * TBL_WORDS_TMNT2 + GRANT_MAX + 40;
    localparam int WATCHDOG_NS =
        2 * CLK_NS * ((2 * N_ROUNDS + 1) * RUN_CYCLES + 2 * N_MIX + 200);

    logic       clk, rst;
    logic [3:0] prog_addr;
    dbg_t       prog_data, debug_bus, debug_view;
    logic       prog_we, header, cpu_we, prot_cs, oram_cs;
    oaddr_t     cpu_addr;
    word_t      cpu_din, cpu_dout, ram_data;
    logic       bus_grant_n, bus_req_n, bus_ack_n, irq_n;
    saddr_t     ram_addr, addr_hold;

    // Reference model state
    integer   seed;
    word_t    main_ram [0:8191];
    word_t    exp_oram [0:127];
    game_id_t exp_game;
    int       exp_len;
    int       grant_delay;
    int       req_falls;
    logic     req_prev;
    int       error_count, check_count, test_count, mark;

    tb_clk u_clk (.clk(clk));

    riders_game i_riders_game (.*);

    function automatic int rnd(input int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    function automatic dbg_t status_byte(input logic grant_n, input logic ack_n,
                                         input logic req_n, input logic irq_l,
                                         input logic [2:0] code);
        return {1'b0, grant_n, ack_n, req_n, irq_l, code};
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t ns",
                     name, got, expected, $time);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic end_test(input string name);
        $display("[%0d] %s: %s, %0d errors", test_count, name,
                 (error_count == mark) ? "passed" : "failed", error_count - mark);
        test_count++;
        mark = error_count;
    endtask

    task automatic write_header(input logic [3:0] addr, input dbg_t data, input logic hdr);
        prog_addr = addr;
        prog_data = data;
        header = hdr;
        prog_we = 1'b1;
        tick();
        prog_we = 1'b0;
        header = 1'b0;
    endtask

    task automatic set_game(input game_id_t id);
        write_header(HDR_GAME_ADDR, {5'(rnd(32)), id}, 1'b1);
        exp_game = id;
        exp_len = (id == GAME_TMNT2) ? TBL_WORDS_TMNT2 : TBL_WORDS_SSR;
    endtask

    task automatic prot_write(input logic reg_sel, input word_t data);
        cpu_addr = {6'(rnd(64)), reg_sel};
        cpu_din = data;
        cpu_we = 1'b1;
        prot_cs = 1'b1;
        tick();
        cpu_we = 1'b0;
        prot_cs = 1'b0;
    endtask

    task automatic oram_write(input oaddr_t addr, input word_t data);
        cpu_addr = addr;
        cpu_din = data;
        cpu_we = 1'b1;
        oram_cs = 1'b1;
        tick();
        cpu_we = 1'b0;
        oram_cs = 1'b0;
        exp_oram[addr] = data;
    endtask

    task automatic oram_read_check(input oaddr_t addr);
        cpu_addr = addr;
        cpu_we = 1'b0;
        oram_cs = 1'b1;
        tick();
        oram_cs = 1'b0;
        check("cpu_dout", 32'(cpu_dout), 32'(exp_oram[addr]));
    endtask

    // Start a copy from base and follow it up to the interrupt
    task automatic run_copy(input saddr_t base);
        int waited;
        int falls_mark;
        falls_mark = req_falls;
        grant_delay = rnd(GRANT_MAX + 1);
        prot_write(REG_BASE, {3'(rnd(8)), base});
        check("bus_req_n", 32'(bus_req_n), 32'd0);
        waited = 0;
        while (bus_ack_n && waited < GRANT_MAX + 4) begin
            tick();
            waited++;
        end
        if (bus_ack_n) begin
            report_error("bus acknowledge never followed the request");
            return;
        end
        // Grant is sampled on the edge after the responder drives it
        check("bus_ack_n delay", 32'(waited), 32'(grant_delay + 1));
        // ACK cycle, addresses start in the next one
        check("bus_req_n", 32'(bus_req_n), 32'd1);
        tick();
        for (int k = 0; k < exp_len; k++) begin
            check("ram_addr", 32'(ram_addr), 32'(saddr_t'(32'(base) + k)));
            check("bus_ack_n", 32'(bus_ack_n), 32'd0);
            exp_oram[k] = main_ram[saddr_t'(32'(base) + k)];
            tick();
        end
        check("bus_ack_n", 32'(bus_ack_n), 32'd0);
        check("irq_n", 32'(irq_n), 32'd1);
        tick();
        check("bus_ack_n", 32'(bus_ack_n), 32'd1);
        check("irq_n", 32'(irq_n), 32'd0);
        check("bus_req_n falls", 32'(req_falls - falls_mark), 32'd1);
    endtask

    task automatic ack_irq();
        prot_write(REG_ACK, word_t'(rnd(65536)));
        check("irq_n", 32'(irq_n), 32'd1);
        check("bus_req_n", 32'(bus_req_n), 32'd1);
    endtask

    task automatic copy_title(input game_id_t id, input string name);
        set_game(id);
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int a = 0; a < 128; a++) begin
                oram_write(oaddr_t'(a), word_t'(rnd(65536)));
            end
            run_copy(saddr_t'(rnd(8192)));
            ack_irq();
            for (int a = 0; a < 128; a++) begin
                oram_read_check(oaddr_t'(a));
            end
        end
        end_test(name);
    endtask

    // Bus grant responder
    initial begin
        bus_grant_n = 1'b1;
        forever begin
            tick();
            if (!rst && !bus_req_n) begin
                repeat (grant_delay) tick();
                bus_grant_n = 1'b0;
                do begin
                    tick();
                end while (bus_ack_n);
                do begin
                    tick();
                end while (!bus_ack_n);
                bus_grant_n = 1'b1;
            end
        end
    end

    // Main work RAM, one clock read latency
    initial begin
        ram_data = '0;
        forever begin
            @(negedge clk);
            addr_hold = ram_addr;
            tick();
            ram_data = main_ram[addr_hold];
        end
    end

    // Count bus requests
    initial begin
        req_falls = 0;
        req_prev = 1'b1;
        forever begin
            @(negedge clk);
            if (req_prev && !bus_req_n) begin
                req_falls++;
            end
            req_prev = bus_req_n;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed = SEED;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        mark = 0;
        grant_delay = 0;
        exp_game = GAME_SSRIDERS;
        exp_len = TBL_WORDS_SSR;
        rst = 1'b1;
        prog_addr = '0;
        prog_data = '0;
        prog_we = 1'b0;
        header = 1'b0;
        cpu_addr = '0;
        cpu_din = '0;
        cpu_we = 1'b0;
        prot_cs = 1'b0;
        oram_cs = 1'b0;
        debug_bus = '0;
        for (int a = 0; a < 8192; a++) begin
            main_ram[a] = word_t'($random(seed));
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        check("bus_req_n", 32'(bus_req_n), 32'd1);
        check("bus_ack_n", 32'(bus_ack_n), 32'd1);
        check("irq_n", 32'(irq_n), 32'd1);
        check("debug_view", 32'(debug_view), 32'd0);
        end_test("reset");

        // Game id page, reset value first
        debug_bus = {2'b11, 6'(rnd(64))};
        tick();
        check("debug_view", 32'(debug_view), 32'(GAME_SSRIDERS));
        for (int i = 0; i < 3; i++) begin
            set_game((i % 2 == 0) ? GAME_TMNT2 : GAME_SSRIDERS);
            tick();
            check("debug_view", 32'(debug_view), 32'(exp_game));
        end
        for (int i = 0; i < 4; i++) begin
            write_header(4'(rnd(15)), dbg_t'(rnd(256)), 1'b1);
            tick();
            check("debug_view", 32'(debug_view), 32'(exp_game));
        end
        write_header(HDR_GAME_ADDR, {5'(rnd(32)), GAME_SSRIDERS}, 1'b0);
        tick();
        check("debug_view", 32'(debug_view), 32'(exp_game));
        end_test("header");

        copy_title(GAME_SSRIDERS, "copy_ssr");
        copy_title(GAME_TMNT2, "copy_tmnt2");

        set_game(GAME_SSRIDERS);
        run_copy(saddr_t'(rnd(8192)));
        repeat (rnd(8) + 2) begin
            tick();
            check("irq_n", 32'(irq_n), 32'd0);
        end
        // Base write with the interrupt pending must not start a copy
        prot_write(REG_BASE, word_t'(rnd(65536)));
        repeat (4) begin
            check("bus_req_n", 32'(bus_req_n), 32'd1);
            check("irq_n", 32'(irq_n), 32'd0);
            tick();
        end
        ack_irq();
        repeat (3) begin
            tick();
            check("bus_req_n", 32'(bus_req_n), 32'd1);
        end
        end_test("irq_hold");

        for (int i = 0; i < N_MIX; i++) begin
            if (rnd(2) == 0) begin
                oram_write(oaddr_t'(rnd(128)), word_t'(rnd(65536)));
            end else begin
                oram_read_check(oaddr_t'(rnd(128)));
            end
        end
        end_test("cpu_mix");

        for (int i = 0; i < 8; i++) begin
            if (rnd(2) == 0) begin
                debug_bus = {2'b00, 6'(rnd(64))};
                tick();
                // Idle, all bus lines released, state code zero
                check("debug_view", 32'(debug_view),
                      32'(status_byte(1'b1, 1'b1, 1'b1, 1'b1, 3'd0)));
            end else begin
                debug_bus = {2'b10, 6'(rnd(64))};
                tick();
                check("debug_view", 32'(debug_view), 32'd0);
            end
        end
        end_test("debug_sel");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== riders.f ====
rtl/riders_pkg.sv
rtl/riders_dma_if.sv
rtl/riders_cfg.sv
rtl/riders_dma_ctrl.sv
rtl/riders_dma_count.sv
rtl/riders_oram.sv
rtl/riders_game.sv
verification/tb_clk.sv
verification/tb_riders.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the object DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_riders -Mdir obj_dir -f riders.f

status=0
output=$(./obj_dir/Vtb_riders) || status=$?
echo "$output"

if echo "$output" | grep -q "TEST OK"; then
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1
